// File: verilog/neuro_cfg.svh
`ifndef NEURO_CFG_SVH
`define NEURO_CFG_SVH

// pool size, 64 motor neurons
`define NEURO_NN_LOG        6
`define NEURO_NN            (1 << `NEURO_NN_LOG)

// datapath widths
`define NEURO_SAMPLE_W      16
`define NEURO_POT_W         26
`define NEURO_GAIN_SHIFT    8
`define NEURO_CNT_W         32

// waveform memory, last slot stays unused
`define NEURO_WAVE_DEPTH    256
`define NEURO_WAVE_AW       8

// parameter reset values
`define NEURO_RST_GAIN      16'd256
`define NEURO_RST_THR_BASE  16'd4000
`define NEURO_RST_THR_STEP  16'd500
// 0.9 in Q16
`define NEURO_RST_OVR_LEN   16'd58982
`define NEURO_RST_OVR_EN    1'b1

// word addresses on the host bus
`define NEURO_REG_CTRL         4'd0
`define NEURO_REG_SRC          4'd1
`define NEURO_REG_GAIN         4'd2
`define NEURO_REG_THR_BASE     4'd3
`define NEURO_REG_THR_STEP     4'd4
`define NEURO_REG_WAVE_DATA    4'd5
`define NEURO_REG_WAVE_CLEAR   4'd6
`define NEURO_REG_STATUS       4'd7
`define NEURO_REG_SPIKE_TOTAL  4'd8
`define NEURO_REG_RECRUITED    4'd9

`endif

// File: verilog/host_pkg.sv
`default_nettype none

package host_pkg;

    ////////////////////////////////////////////////////////////////////
    // wishbone classic, word addressed, 32 bit data
    ////////////////////////////////////////////////////////////////////

    // master to slave, held until ack
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        // word address
        logic [3:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic        ack;
        // read data, valid with ack
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

// File: verilog/neuro_pkg.sv
`default_nettype none

`include "neuro_cfg.svh"

package neuro_pkg;

    ////////////////////////////////////////////////////////////////////
    // simulation datapath types
    ////////////////////////////////////////////////////////////////////

    // muscle length, unsigned, 1.0 = 65536
    typedef logic [`NEURO_SAMPLE_W-1:0] sample_t;

    // pool parameters from the host
    typedef struct packed {
        // drive = len * gain >> 8, 256 is unity
        logic [15:0] gain;
        // threshold of neuron i is thr_base + i * thr_step
        logic [15:0] thr_base;
        logic [15:0] thr_step;
        // constant length instead of the waveform
        logic        override_en;
        sample_t     override_len;
    } pool_cfg_t;

    // one spike, at most one per cycle
    typedef struct packed {
        logic                     valid;
        logic [`NEURO_NN_LOG-1:0] id;
    } spike_evt_t;

endpackage

`default_nettype wire

// File: verilog/host_regs.sv
`default_nettype none

`include "neuro_cfg.svh"

module host_regs
(
    input  wire                       ep50trig,
    input  wire                       reset_global,
    input  wire host_pkg::wb_req_t    i_wb,
    output host_pkg::wb_rsp_t         o_wb,
    output neuro_pkg::pool_cfg_t      o_cfg,
    output logic                      o_burst_start,
    output logic [15:0]               o_sweeps,
    output logic                      o_wave_push,
    output logic                      o_wave_clear,
    output neuro_pkg::sample_t        o_wave_data,
    input  wire                       i_busy,
    input  wire [`NEURO_WAVE_AW-1:0]  i_wave_len,
    input  wire [`NEURO_CNT_W-1:0]    i_total,
    input  wire [`NEURO_NN_LOG:0]     i_recruited
);

    // new cycle seen, not yet acked
    logic        access;
    logic        wr_en;
    logic        ack_q;
    logic [31:0] rd_mux;
    logic [31:0] rdat_q;

    assign access = i_wb.cyc && i_wb.stb && !ack_q;
    assign wr_en  = access && i_wb.we;
    assign o_wb   = '{ack: ack_q, dat: rdat_q};

    //////////////////////////////////////////////////////////////////////
    // read mux
    //////////////////////////////////////////////////////////////////////
    always_comb
    begin
        case (i_wb.adr)
            `NEURO_REG_CTRL:        rd_mux = {16'd0, o_sweeps};
            `NEURO_REG_SRC:         rd_mux = {15'd0, o_cfg.override_en, o_cfg.override_len};
            `NEURO_REG_GAIN:        rd_mux = {16'd0, o_cfg.gain};
            `NEURO_REG_THR_BASE:    rd_mux = {16'd0, o_cfg.thr_base};
            `NEURO_REG_THR_STEP:    rd_mux = {16'd0, o_cfg.thr_step};
            // busy in bit 0, wave length in 15:8
            `NEURO_REG_STATUS:      rd_mux = {16'd0, i_wave_len, 7'd0, i_busy};
            `NEURO_REG_SPIKE_TOTAL: rd_mux = i_total;
            `NEURO_REG_RECRUITED:   rd_mux = {{(31 - `NEURO_NN_LOG){1'b0}}, i_recruited};
            default:                rd_mux = 32'd0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // handshake, command pulses, parameter registers
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            ack_q              <= 1'b0;
            o_burst_start      <= 1'b0;
            o_wave_push        <= 1'b0;
            o_wave_clear       <= 1'b0;
            o_sweeps           <= 16'd0;
            o_cfg.gain         <= `NEURO_RST_GAIN;
            o_cfg.thr_base     <= `NEURO_RST_THR_BASE;
            o_cfg.thr_step     <= `NEURO_RST_THR_STEP;
            o_cfg.override_en  <= `NEURO_RST_OVR_EN;
            o_cfg.override_len <= `NEURO_RST_OVR_LEN;
        end
        else
        begin
            // one ack per request, drops with stb
            ack_q         <= access;
            // start ignored during a burst
            o_burst_start <= wr_en && (i_wb.adr == `NEURO_REG_CTRL) && !i_busy;
            o_wave_push   <= wr_en && (i_wb.adr == `NEURO_REG_WAVE_DATA);
            o_wave_clear  <= wr_en && (i_wb.adr == `NEURO_REG_WAVE_CLEAR);
            if (wr_en)
            begin
                case (i_wb.adr)
                    `NEURO_REG_CTRL:
                    begin
                        if (!i_busy)
                        begin
                            o_sweeps <= i_wb.dat[15:0];
                        end
                    end
                    `NEURO_REG_SRC:
                    begin
                        o_cfg.override_en  <= i_wb.dat[16];
                        o_cfg.override_len <= i_wb.dat[15:0];
                    end
                    `NEURO_REG_GAIN:     o_cfg.gain     <= i_wb.dat[15:0];
                    `NEURO_REG_THR_BASE: o_cfg.thr_base <= i_wb.dat[15:0];
                    `NEURO_REG_THR_STEP: o_cfg.thr_step <= i_wb.dat[15:0];
                    default:
                    begin
                    end
                endcase
            end
        end
    end

    // read data and pushed sample
    always_ff @(posedge ep50trig)
    begin
        if (access)
        begin
            rdat_q <= rd_mux;
        end
        if (wr_en && (i_wb.adr == `NEURO_REG_WAVE_DATA))
        begin
            o_wave_data <= i_wb.dat[`NEURO_SAMPLE_W-1:0];
        end
    end

    // master keeps stb up until it sees ack
    assert property (@(posedge ep50trig) disable iff (reset_global)
        ack_q |-> i_wb.stb);

endmodule

`default_nettype wire

// File: verilog/wave_buffer.sv
`default_nettype none

`include "neuro_cfg.svh"

module wave_buffer
(
    input  wire                          ep50trig,
    input  wire                          reset_global,
    input  wire                          i_push,
    input  wire                          i_clear,
    input  wire neuro_pkg::sample_t      i_data,
    input  wire                          i_restart,
    input  wire                          i_advance,
    output neuro_pkg::sample_t           o_sample,
    output logic [`NEURO_WAVE_AW-1:0]    o_length
);

    neuro_pkg::sample_t mem [`NEURO_WAVE_DEPTH];

    // one spare bit so an overrun would show
    logic [`NEURO_WAVE_AW:0]   wr_ptr;
    logic [`NEURO_WAVE_AW-1:0] rd_idx;
    logic [`NEURO_WAVE_AW-1:0] rd_next;
    logic                      full;

    // length capped one below depth, fits the status byte
    assign full     = (wr_ptr == `NEURO_WAVE_DEPTH - 1);
    assign o_length = wr_ptr[`NEURO_WAVE_AW-1:0];
    assign rd_next  = rd_idx + 1'b1;

    // empty buffer plays silence
    assign o_sample = (o_length == '0) ? '0 : mem[rd_idx];

    //////////////////////////////////////////////////////////////////////
    // append pointer and playback index
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            wr_ptr <= '0;
            rd_idx <= '0;
        end
        else
        begin
            if (i_clear)
                wr_ptr <= '0;
            else if (i_push && !full)
                wr_ptr <= wr_ptr + 1'b1;
            // wrap at the current length
            if (i_restart)
                rd_idx <= '0;
            else if (i_advance)
                rd_idx <= (rd_next >= o_length) ? '0 : rd_next;
        end
    end

    // sample store, push on a full buffer dropped
    always_ff @(posedge ep50trig)
    begin
        if (i_push && !full)
        begin
            mem[wr_ptr[`NEURO_WAVE_AW-1:0]] <= i_data;
        end
    end

    assert property (@(posedge ep50trig) disable iff (reset_global)
        wr_ptr < `NEURO_WAVE_DEPTH);

endmodule

`default_nettype wire

// File: verilog/neuron_pool.sv
`default_nettype none

`include "neuro_cfg.svh"

module neuron_pool
(
    input  wire                         ep50trig,
    input  wire                         reset_global,
    input  wire neuro_pkg::pool_cfg_t   i_cfg,
    input  wire neuro_pkg::sample_t     i_sample,
    input  wire                         i_burst_start,
    input  wire [15:0]                  i_sweeps,
    output logic                        o_busy,
    output logic                        o_advance,
    output neuro_pkg::spike_evt_t       o_spike
);

    // issue side
    logic                       run;
    logic                       first_sweep;
    logic [15:0]                sweeps_left;
    logic [`NEURO_NN_LOG-1:0]   n_idx;
    logic                       last_idx;

    // drive, fixed per sweep
    neuro_pkg::sample_t         src_len;
    logic [31:0]                scaled;
    logic [`NEURO_POT_W-1:0]    drive_q;

    // potentials and the two pipeline stages
    logic [`NEURO_POT_W-1:0]    pot_mem [`NEURO_NN];
    logic                       s1_vld;
    logic                       s1_first;
    logic [`NEURO_NN_LOG-1:0]   s1_idx;
    logic [`NEURO_POT_W-1:0]    s1_pot;
    logic [`NEURO_POT_W-1:0]    pot_in;
    logic [`NEURO_POT_W-1:0]    sum;
    logic [`NEURO_POT_W-1:0]    thr;
    logic                       fire;

    assign last_idx  = &n_idx;
    assign o_busy    = run || s1_vld;
    // index moves at the end of the sweep, sample ready for neuron 0
    assign o_advance = run && last_idx;

    assign src_len = i_cfg.override_en ? i_cfg.override_len : i_sample;
    assign scaled  = (src_len * i_cfg.gain) >> `NEURO_GAIN_SHIFT;

    //////////////////////////////////////////////////////////////////////
    // sweep and neuron counters
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            run         <= 1'b0;
            first_sweep <= 1'b0;
            sweeps_left <= 16'd0;
            n_idx       <= '0;
            s1_vld      <= 1'b0;
        end
        else
        begin
            s1_vld <= run;
            // zero sweeps, nothing to run
            if (i_burst_start && (i_sweeps != 16'd0))
            begin
                run         <= 1'b1;
                first_sweep <= 1'b1;
                sweeps_left <= i_sweeps;
                n_idx       <= '0;
            end
            else if (run)
            begin
                n_idx <= n_idx + 1'b1;
                if (last_idx)
                begin
                    first_sweep <= 1'b0;
                    sweeps_left <= sweeps_left - 1'b1;
                    if (sweeps_left == 16'd1)
                        run <= 1'b0;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stage one reads, stage two integrates and writes back
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge ep50trig)
    begin
        s1_idx   <= n_idx;
        s1_first <= first_sweep;
        s1_pot   <= pot_mem[n_idx];
        // latched together with neuron 0 entering stage one
        if (run && (n_idx == '0))
        begin
            drive_q <= scaled[`NEURO_POT_W-1:0];
        end
        if (s1_vld)
        begin
            pot_mem[s1_idx] <= fire ? (sum - thr) : sum;
        end
    end

    // first sweep starts from rest, stands in for a memory clear
    assign pot_in = s1_first ? '0 : s1_pot;
    assign sum    = pot_in + drive_q;
    // larger neurons sit higher, recruited later
    assign thr    = `NEURO_POT_W'(i_cfg.thr_base)
                  + `NEURO_POT_W'(s1_idx) * `NEURO_POT_W'(i_cfg.thr_step);
    assign fire   = s1_vld && (sum >= thr);

    assign o_spike = '{valid: fire, id: s1_idx};

    // spikes only within a burst
    assert property (@(posedge ep50trig) disable iff (reset_global)
        o_spike.valid |-> o_busy);

endmodule

`default_nettype wire

// File: verilog/spike_tally.sv
`default_nettype none

`include "neuro_cfg.svh"

module spike_tally
(
    input  wire                          ep50trig,
    input  wire                          reset_global,
    input  wire                          i_burst_start,
    input  wire neuro_pkg::spike_evt_t   i_spike,
    output logic [`NEURO_CNT_W-1:0]      o_total,
    output logic [`NEURO_NN_LOG:0]       o_recruited
);

    // neurons seen firing this burst
    logic [`NEURO_NN-1:0] fired;
    logic                 first_fire;

    assign first_fire = i_spike.valid && !fired[i_spike.id];

    //////////////////////////////////////////////////////////////////////
    // totals, cleared per burst
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge ep50trig)
    begin
        if (reset_global || i_burst_start)
        begin
            fired       <= '0;
            o_total     <= '0;
            o_recruited <= '0;
        end
        else
        begin
            // saturate at all ones
            if (i_spike.valid && !(&o_total))
                o_total <= o_total + 1'b1;
            // population count grows with the mask
            if (first_fire)
            begin
                fired[i_spike.id] <= 1'b1;
                o_recruited       <= o_recruited + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/neuro_top.sv
`default_nettype none

`include "neuro_cfg.svh"

module neuro_top
(
    input  wire                        ep50trig,
    input  wire                        reset_global,
    input  wire host_pkg::wb_req_t     i_wb,
    output host_pkg::wb_rsp_t          o_wb
);

    // host commands
    neuro_pkg::pool_cfg_t       cfg;
    logic                       burst_start;
    logic [15:0]                sweeps;
    logic                       wave_push;
    logic                       wave_clear;
    neuro_pkg::sample_t         wave_data;

    // pool and playback
    logic                       busy;
    logic                       advance;
    neuro_pkg::sample_t         sample;
    logic [`NEURO_WAVE_AW-1:0]  wave_len;
    neuro_pkg::spike_evt_t      spike;

    // results back to the bus
    logic [`NEURO_CNT_W-1:0]    total;
    logic [`NEURO_NN_LOG:0]     recruited;

    host_regs host_regs_i
    (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_wb          (i_wb),
        .o_wb          (o_wb),
        .o_cfg         (cfg),
        .o_burst_start (burst_start),
        .o_sweeps      (sweeps),
        .o_wave_push   (wave_push),
        .o_wave_clear  (wave_clear),
        .o_wave_data   (wave_data),
        .i_busy        (busy),
        .i_wave_len    (wave_len),
        .i_total       (total),
        .i_recruited   (recruited)
    );

    // playback restarts with every burst
    wave_buffer wave_buffer_i
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_push       (wave_push),
        .i_clear      (wave_clear),
        .i_data       (wave_data),
        .i_restart    (burst_start),
        .i_advance    (advance),
        .o_sample     (sample),
        .o_length     (wave_len)
    );

    neuron_pool neuron_pool_i
    (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_cfg         (cfg),
        .i_sample      (sample),
        .i_burst_start (burst_start),
        .i_sweeps      (sweeps),
        .o_busy        (busy),
        .o_advance     (advance),
        .o_spike       (spike)
    );

    spike_tally spike_tally_i
    (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_burst_start (burst_start),
        .i_spike       (spike),
        .o_total       (total),
        .o_recruited   (recruited)
    );

endmodule

`default_nettype wire

// File: tests/neuro_tb.sv
`default_nettype none

`include "neuro_cfg.svh"

module neuro_tb;

    localparam int NUM_ROWS  = 9;
    localparam int ACK_LIMIT = 20;
    localparam int NN        = `NEURO_NN;

    // one table row, expected counts come from the model
    typedef struct packed {
        logic [7:0]  nsamp;
        logic        ovr_en;
        logic [15:0] ovr_len;
        logic [15:0] gain;
        logic [15:0] thr_base;
        logic [15:0] thr_step;
        logic [15:0] sweeps;
        // second start while busy
        logic        restart;
    } row_t;

    logic               ep50trig;
    logic               reset_global;
    host_pkg::wb_req_t  wb_req;
    host_pkg::wb_rsp_t  wb_rsp;

    row_t        rows [NUM_ROWS];
    // copy of the samples pushed into the DUT
    logic [15:0] wave [256];
    integer      seed;
    int          value_errors;
    int          other_errors;

    neuro_top neuro_top_i
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_wb         (wb_req),
        .o_wb         (wb_rsp)
    );

    initial
    begin
        ep50trig = 1'b0;
        forever #50 ep50trig = ~ep50trig;
    end

    function automatic row_t make_row(input int nsamp, input bit ovr_en, input int ovr_len,
                                      input int gain, input int thr_base, input int thr_step,
                                      input int sweeps, input bit restart);
        row_t r;
        r.nsamp    = nsamp[7:0];
        r.ovr_en   = ovr_en;
        r.ovr_len  = ovr_len[15:0];
        r.gain     = gain[15:0];
        r.thr_base = thr_base[15:0];
        r.thr_step = thr_step[15:0];
        r.sweeps   = sweeps[15:0];
        r.restart  = restart;
        return r;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // stimulus table
    //////////////////////////////////////////////////////////////////////
    task automatic fill_table();
        // constant length, varied gain and slope
        rows[0] = make_row(0, 1'b1, 58982, 256, 4000, 500, 3, 1'b0);
        rows[1] = make_row(0, 1'b1, 30000, 32, 1000, 300, 10, 1'b0);
        rows[2] = make_row(0, 1'b1, 20000, 128, 5000, 1000, 8, 1'b0);
        // wave playback, more sweeps than samples
        rows[3] = make_row(20, 1'b0, 0, 64, 2000, 400, 50, 1'b0);
        rows[4] = make_row(7, 1'b0, 0, 200, 3000, 2000, 30, 1'b0);
        // cleared wave plays zeros
        rows[5] = make_row(0, 1'b0, 0, 256, 4000, 500, 4, 1'b0);
        // no gain, no drive
        rows[6] = make_row(0, 1'b1, 50000, 0, 4000, 500, 5, 1'b0);
        // start during a burst, then a fresh burst
        rows[7] = make_row(0, 1'b1, 40000, 100, 6000, 700, 6, 1'b1);
        rows[8] = make_row(0, 1'b1, 12000, 256, 3000, 250, 4, 1'b0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // wishbone classic master
    //////////////////////////////////////////////////////////////////////
    task automatic bus_access(input logic we, input logic [3:0] adr, input logic [31:0] dat,
                              output logic [31:0] rdat);
        int waited;
        waited = 0;
        @(negedge ep50trig);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        @(negedge ep50trig);
        while (!wb_rsp.ack && waited < ACK_LIMIT)
        begin
            waited++;
            @(negedge ep50trig);
        end
        assert (wb_rsp.ack)
        else
        begin
            $display("no ack from the bus for address %0d within %0d cycles", adr, ACK_LIMIT);
            other_errors++;
        end
        rdat = wb_rsp.dat;
        // stb stays up over the ack edge
        @(negedge ep50trig);
        wb_req = '0;
    endtask

    task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        bus_access(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [31:0] dat);
        bus_access(1'b0, adr, 32'd0, dat);
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_reg(input logic [3:0] adr, input string name,
                             input logic [31:0] exp);
        logic [31:0] val;
        wb_read(adr, val);
        check_val(name, val, exp);
    endtask

    // poll status until busy drops
    task automatic wait_idle(input int limit);
        logic [31:0] st;
        int          polls;
        polls = 0;
        st    = 32'd1;
        while (st[0] && polls < limit)
        begin
            wb_read(`NEURO_REG_STATUS, st);
            polls++;
        end
        assert (!st[0])
        else
        begin
            $display("burst still busy after %0d status reads", limit);
            other_errors++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model, one burst
    //////////////////////////////////////////////////////////////////////
    task automatic model_burst(input row_t r, output int total, output int recruited);
        longint pot [NN];
        bit     fired [NN];
        longint drive;
        longint thr;
        int     len;
        int     s;
        int     i;
        total     = 0;
        recruited = 0;
        for (i = 0; i < NN; i++)
        begin
            pot[i]   = 0;
            fired[i] = 1'b0;
        end
        for (s = 0; s < int'(r.sweeps); s++)
        begin
            // drive fixed for the whole sweep
            if (r.ovr_en)
                len = int'(r.ovr_len);
            else if (r.nsamp == 8'd0)
                len = 0;
            else
                len = int'(wave[s % int'(r.nsamp)]);
            drive = (longint'(len) * longint'(r.gain)) >> `NEURO_GAIN_SHIFT;
            for (i = 0; i < NN; i++)
            begin
                thr    = longint'(r.thr_base) + longint'(i) * longint'(r.thr_step);
                pot[i] = pot[i] + drive;
                // one spike per visit at most
                if (pot[i] >= thr)
                begin
                    pot[i] = pot[i] - thr;
                    total++;
                    if (!fired[i])
                    begin
                        fired[i] = 1'b1;
                        recruited++;
                    end
                end
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // apply one row
    //////////////////////////////////////////////////////////////////////
    task automatic run_row(input int k);
        row_t r;
        int   exp_total;
        int   exp_rec;
        int   j;
        r = rows[k];
        // reload the wave only when it is played
        if (!r.ovr_en)
        begin
            wb_write(`NEURO_REG_WAVE_CLEAR, 32'd0);
            for (j = 0; j < int'(r.nsamp); j++)
            begin
                wave[j] = 16'($random(seed));
                wb_write(`NEURO_REG_WAVE_DATA, {16'd0, wave[j]});
            end
            check_reg(`NEURO_REG_STATUS, "wave_len", {16'd0, r.nsamp, 8'd0});
        end
        wb_write(`NEURO_REG_SRC, {15'd0, r.ovr_en, r.ovr_len});
        wb_write(`NEURO_REG_GAIN, {16'd0, r.gain});
        wb_write(`NEURO_REG_THR_BASE, {16'd0, r.thr_base});
        wb_write(`NEURO_REG_THR_STEP, {16'd0, r.thr_step});
        wb_write(`NEURO_REG_CTRL, {16'd0, r.sweeps});
        // must be dropped, pool already busy
        if (r.restart)
            wb_write(`NEURO_REG_CTRL, {16'd0, r.sweeps + 16'd5});
        wait_idle(int'(r.sweeps) * 64 + 16);
        if (r.restart)
            check_reg(`NEURO_REG_CTRL, "sweeps", {16'd0, r.sweeps});
        model_burst(r, exp_total, exp_rec);
        check_reg(`NEURO_REG_SPIKE_TOTAL, "spike_total", exp_total);
        check_reg(`NEURO_REG_RECRUITED, "recruited", exp_rec);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////
    initial
    begin
        int k;
        seed         = 32'h8bc3ec5d;
        value_errors = 0;
        other_errors = 0;
        wb_req       = '0;
        reset_global = 1'b1;
        fill_table();
        repeat (2) @(negedge ep50trig);
        reset_global = 1'b0;

        // reset values
        check_reg(`NEURO_REG_CTRL, "sweeps", 32'd0);
        check_reg(`NEURO_REG_SRC, "src", {15'd0, 1'b1, 16'd58982});
        check_reg(`NEURO_REG_GAIN, "gain", 32'd256);
        check_reg(`NEURO_REG_THR_BASE, "thr_base", 32'd4000);
        check_reg(`NEURO_REG_THR_STEP, "thr_step", 32'd500);
        check_reg(`NEURO_REG_STATUS, "status", 32'd0);
        check_reg(`NEURO_REG_SPIKE_TOTAL, "spike_total", 32'd0);
        check_reg(`NEURO_REG_RECRUITED, "recruited", 32'd0);

        for (k = 0; k < NUM_ROWS; k++)
            run_row(k);

        $display("value errors %0d, other errors %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog, sized by the table
    initial
    begin
        longint limit;
        int     k;
        #1;
        limit = 2000;
        for (k = 0; k < NUM_ROWS; k++)
            limit = limit + longint'(rows[k].sweeps) * 64 + longint'(rows[k].nsamp) * 4 + 64;
        #(limit * 100);
        $display("watchdog expired after %0d clock periods", limit);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+verilog
verilog/host_pkg.sv
verilog/neuro_pkg.sv
verilog/host_regs.sv
verilog/wave_buffer.sv
verilog/neuron_pool.sv
verilog/spike_tally.sv
verilog/neuro_top.sv
tests/neuro_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the neuro testbench with verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module neuro_tb -o Vneuro_tb

./obj_dir/Vneuro_tb > sim.log 2>&1
cat sim.log

# pass only when the testbench printed its pass line
if grep -qx "test passed" sim.log; then
    exit 0
else
    exit 1
fi
